/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module fibEngineTb \
		-f fibEngine.f --Mdir obj_dir -o fibSim
	./obj_dir/fibSim | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/fibEngineTb.sv */
`timescale 1ns/100ps
`default_nettype none

module fibEngineTb
    import fibDataPkg::*;
();

    localparam int dataWidth   = 32;
    localparam int indexWidth  = 6;
    localparam int queuedCount = 12;
    // base 3, sweep 45, overflow 16 plus one, queued, handshake 4
    localparam int itemCount   = 3 + 45 + 17 + queuedCount + 4;
    // worst loop, setup, handshakes, longest ack delay
    localparam int itemCycles  = 4 + 3 * 63 + 20 + 30;
    localparam int watchdogCycles = itemCount * itemCycles + 200;

    logic                  clk;
    logic                  rstN;
    logic                  inReq;
    logic [indexWidth-1:0] inIndex;
    logic                  inAck;
    logic                  outReq;
    logic                  outAck;
    fibResult_t            outResult;

    int     errorCount;
    int     checkCount;
    integer seed;
    logic   prevInAck;
    logic   prevOutReq;

    fibEngine #(.dataWidth(dataWidth), .indexWidth(indexWidth)) DUT (
        .clk(clk), .rstN(rstN), .inReq(inReq), .inIndex(inIndex), .outAck(outAck),
        .inAck(inAck), .outReq(outReq), .outResult(outResult)
    );

    bind fibEngine fibEngineAsserts uAsserts (
        .clk(clk), .rstN(rstN), .inReq(inReq), .inAck(inAck), .outReq(outReq),
        .outAck(outAck), .outResult(outResult), .ctrl(ctrl),
        .resultLoad(resultLoad)
    );

    // 100 ns period
    always #50 clk = ~clk;

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic checkValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // fib(n) mod 2^32, carry sticky over every add of the loop
    function automatic fibResult_t fibModel(input int n);
        logic [32:0] s;
        logic [31:0] a;
        logic [31:0] b;
        fibResult_t  r;
        a = '0;
        b = 32'd1;
        r.overflow = 1'b0;
        for (int i = 0; i < n; i++) begin
            s = {1'b0, a} + {1'b0, b};
            r.overflow = r.overflow | s[32];
            a = b;
            b = s[31:0];
        end
        r.value = a;
        return r;
    endfunction

    task automatic applyReset();
        @(posedge clk);
        rstN <= 1'b0;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
    endtask

    // producer side, index held until ack
    task automatic sendIndex(input int n);
        @(posedge clk);
        inIndex <= indexWidth'(n);
        inReq   <= 1'b1;
        @(posedge clk);
        while (!inAck) @(posedge clk);
        inReq <= 1'b0;
        @(posedge clk);
        while (inAck) @(posedge clk);
    endtask

    // consumer side with ack held back
    task automatic takeResult(input int ackDelay, output fibResult_t r);
        @(posedge clk);
        while (!outReq) @(posedge clk);
        r = outResult;
        repeat (ackDelay) begin
            @(posedge clk);
            checkValue("outReq held until outAck", 1, outReq);
        end
        outAck <= 1'b1;
        @(posedge clk);
        while (outReq) @(posedge clk);
        outAck <= 1'b0;
    endtask

    task automatic computeOne(input int n, input int ackDelay, output fibResult_t r);
        fibResult_t got;
        fork
            sendIndex(n);
            takeResult(ackDelay, got);
        join
        r = got;
    endtask

    task automatic checkResult(input string name, input int n, input fibResult_t r);
        fibResult_t expected;
        expected = fibModel(n);
        checkValue($sformatf("%s n=%0d value", name, n), expected.value, r.value);
        checkValue($sformatf("%s n=%0d overflow", name, n), expected.overflow, r.overflow);
    endtask

    //////////////////////////////
    // link monitor
    //////////////////////////////

    // edges seen against pre-edge levels
    always @(posedge clk) begin
        if (rstN) begin
            if (inAck && !prevInAck) begin
                checkValue("handshake inAck rise needs inReq", 1, inReq);
            end
            if (outReq && !prevOutReq) begin
                checkValue("handshake outReq rise needs outAck low", 0, outAck);
            end
            if (!outReq && prevOutReq) begin
                checkValue("handshake outReq fall needs outAck", 1, outAck);
            end
        end
        prevInAck  <= inAck;
        prevOutReq <= outReq;
    end

    //////////////////////////////
    // directed tests
    //////////////////////////////

    task automatic baseCases();
        fibResult_t r;
        for (int n = 0; n < 3; n++) begin
            computeOne(n, 1, r);
            checkResult("base", n, r);
            // fib(0)=0, fib(1)=fib(2)=1
            checkValue($sformatf("base n=%0d literal", n), (n == 0) ? 0 : 1, r.value);
        end
    endtask

    task automatic sweepMidRange();
        fibResult_t r;
        for (int n = 3; n <= 47; n++) begin
            computeOne(n, 0, r);
            checkResult("sweep", n, r);
        end
    endtask

    task automatic overflowRange();
        fibResult_t r;
        for (int n = 48; n <= 63; n++) begin
            computeOne(n, 2, r);
            checkResult("overflow", n, r);
            checkValue($sformatf("overflow n=%0d flag set", n), 1, r.overflow);
        end
        // fresh run starts with a clean flag
        computeOne(5, 0, r);
        checkResult("overflow cleared", 5, r);
    endtask

    task automatic backPressure();
        int         indices[queuedCount];
        int         delays[queuedCount];
        fibResult_t got[$];
        fibResult_t r;
        for (int i = 0; i < queuedCount; i++) begin
            indices[i] = $unsigned($random(seed)) % 64;
            delays[i]  = $unsigned($random(seed)) % 31;
        end
        fork
            begin
                for (int i = 0; i < queuedCount; i++) begin
                    sendIndex(indices[i]);
                end
            end
            begin
                for (int i = 0; i < queuedCount; i++) begin
                    takeResult(delays[i], r);
                    got.push_back(r);
                end
            end
        join
        for (int i = 0; i < queuedCount; i++) begin
            checkResult($sformatf("backpressure item %0d", i), indices[i], got[i]);
        end
    endtask

    task automatic handshakeOrder();
        fibResult_t r;
        // park one result at the sender and a second run behind it
        sendIndex(4);
        @(posedge clk);
        while (!outReq) @(posedge clk);
        inIndex <= indexWidth'(5);
        inReq   <= 1'b1;
        @(posedge clk);
        while (!inAck) @(posedge clk);
        // reset with both links mid handshake
        applyReset();
        inReq <= 1'b0;
        @(posedge clk);
        checkValue("handshake inAck after reset", 0, inAck);
        checkValue("handshake outReq after reset", 0, outReq);
        computeOne(9, 7, r);
        checkResult("handshake", 9, r);
        computeOne(10, 0, r);
        checkResult("handshake", 10, r);
    endtask

    task automatic finishRun();
        errorCount += DUT.uAsserts.failCount;
        $display("checks run %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    //////////////////////////////
    // run
    //////////////////////////////

    initial begin
        clk         = 1'b0;
        rstN        = 1'b0;
        inReq       = 1'b0;
        inIndex     = '0;
        outAck      = 1'b0;
        errorCount  = 0;
        checkCount  = 0;
        prevInAck   = 1'b0;
        prevOutReq  = 1'b0;
        seed        = 32'h0ada52ee;
        applyReset();
        baseCases();
        sweepMidRange();
        overflowRange();
        backPressure();
        handshakeOrder();
        finishRun();
    end

    // watchdog sized from the item count
    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("timeout: the engine stopped answering after %0d cycles", watchdogCycles);
        errorCount++;
        finishRun();
    end

endmodule

`default_nettype wire

/* bench/fibEngine_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module fibEngineAsserts
    import fibDataPkg::*;
    import fibCtrlPkg::*;
(
    input logic       clk,
    input logic       rstN,
    input logic       inReq,
    input logic       inAck,
    input logic       outReq,
    input logic       outAck,
    input fibResult_t outResult,
    input ctrlWord_t  ctrl,
    input logic       resultLoad
);

    // assertion failures so far
    int failCount = 0;

    //////////////////////////////
    // link handshakes
    //////////////////////////////

    // ack only answers a live request
    inAckNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
        $rose(inAck) |-> inReq)
        else begin
            $error("inAck rose while inReq was low");
            failCount++;
        end

    // consumer sees one steady word per request
    outResultHeld: assert property (@(posedge clk) disable iff (!rstN)
        (outReq && $past(outReq)) |-> $stable(outResult))
        else begin
            $error("outResult changed while outReq was high");
            failCount++;
        end

    // req drops only in answer to an ack
    outReqFallAfterAck: assert property (@(posedge clk) disable iff (!rstN)
        $fell(outReq) |-> $past(outAck))
        else begin
            $error("outReq fell without outAck");
            failCount++;
        end

    //////////////////////////////
    // controller
    //////////////////////////////

    // f0 is either cleared or loaded, never both
    f0SingleSource: assert property (@(posedge clk) disable iff (!rstN)
        ctrl.clrOverflow |-> !ctrl.ldF0)
        else begin
            $error("f0 cleared and loaded in the same cycle");
            failCount++;
        end

    // counter value on the bus feeds the counter only
    decBusToCounter: assert property (@(posedge clk) disable iff (!rstN)
        (ctrl.fnSel == fnDec) |-> !(ctrl.ldOut || ctrl.ldF0))
        else begin
            $error("term register loaded from the counter path");
            failCount++;
        end

    // a load only lands in an empty sender, so a fresh request follows
    loadStartsSend: assert property (@(posedge clk) disable iff (!rstN)
        resultLoad |=> $rose(outReq))
        else begin
            $error("resultLoad did not start a new outReq");
            failCount++;
        end

endmodule

`default_nettype wire

/* fibEngine.f */
verilog/fibDataPkg.sv
verilog/fibCtrlPkg.sv
verilog/fibRequestIn.sv
verilog/fibController.sv
verilog/fibDatapath.sv
verilog/fibResultOut.sv
verilog/fibEngine.sv
bench/fibEngine_asserts.sv
bench/fibEngineTb.sv

/* verilog/fibController.sv */
`timescale 1ns/100ps
`default_nettype none

module fibController
    import fibDataPkg::*;
    import fibCtrlPkg::*;
#(
    parameter int indexWidth = defaultIndexWidth
) (
    input  logic      clk,
    input  logic      rstN,
    input  logic      idxValid,
    input  logic      cntZero,
    input  logic      outFree,
    output logic      idxTake,
    output ctrlWord_t ctrl,
    output logic      resultLoad
);

    ctrlState_t state;
    ctrlState_t nextState;

    //////////////////////////////
    // state register
    //////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= sIdle;
        end else begin
            state <= nextState;
        end
    end

    //////////////////////////////
    // next state
    //////////////////////////////

    always_comb begin
        nextState = state;
        case (state)
            sIdle: begin
                if (idxValid) begin
                    nextState = sLoadIndex;
                end
            end
            // setup chain
            sLoadIndex: nextState = sInitTerms;
            sInitTerms: nextState = sLoadCount;
            sLoadCount: nextState = sTest;
            // n of zero skips the loop
            sTest:      nextState = cntZero ? sFinish : sStep;
            // loop body
            sStep:      nextState = sDec;
            sDec:       nextState = sShift;
            // loop ends once the counter reaches zero
            sShift:     nextState = cntZero ? sFinish : sStep;
            // hand off, or park until the sender frees up
            sFinish, sWaitOut: begin
                nextState = outFree ? sIdle : sWaitOut;
            end
            default:    nextState = sIdle;
        endcase
    end

    //////////////////////////////
    // control word decode
    //////////////////////////////

    always_comb begin
        ctrl = '0;
        case (state)
            // index straight in from the receiver
            sLoadIndex: begin
                ctrl.ldIndex = 1'b1;
            end
            // out gets one, f0 and overflow cleared
            sInitTerms: begin
                ctrl.fnSel       = fnOne;
                ctrl.ldOut       = 1'b1;
                ctrl.clrOverflow = 1'b1;
            end
            // counter from index, f1 picks up the one in out
            sLoadCount: begin
                ctrl.fnSel = fnPassIndex;
                ctrl.ldCnt = 1'b1;
                ctrl.ldF1  = 1'b1;
            end
            // out = f0 + f1
            sStep: begin
                ctrl.fnSel = fnAdd;
                ctrl.ldOut = 1'b1;
            end
            // counter down early so the zero flag is ready by shift
            sDec: begin
                ctrl.fnSel = fnDec;
                ctrl.ldCnt = 1'b1;
            end
            // f0 = f1 and f1 = out on the same edge
            sShift: begin
                ctrl.fnSel = fnPassF1;
                ctrl.ldF0  = 1'b1;
                ctrl.ldF1  = 1'b1;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    // pulses
    assign idxTake    = (state == sLoadIndex);
    assign resultLoad = (state == sFinish || state == sWaitOut) && outFree;

endmodule

`default_nettype wire

/* verilog/fibCtrlPkg.sv */
`default_nettype none

package fibCtrlPkg;

    //////////////////////////////
    // function unit opcodes
    //////////////////////////////

    // drives the shared bus
    typedef enum logic [2:0] {
        // f0 plus f1
        fnAdd       = 3'b000,
        // constant one
        fnOne       = 3'b001,
        // index register onto bus
        fnPassIndex = 3'b010,
        // f1 onto bus
        fnPassF1    = 3'b011,
        // counter minus one
        fnDec       = 3'b100
    } fnOp_t;

    //////////////////////////////
    // sequencer states
    //////////////////////////////

    typedef enum logic [3:0] {
        sIdle,
        sLoadIndex,
        sInitTerms,
        sLoadCount,
        sTest,
        sStep,
        sShift,
        sDec,
        sFinish,
        sWaitOut
    } ctrlState_t;

    // one control word per cycle, controller to datapath
    typedef struct packed {
        logic  ldIndex;
        logic  ldCnt;
        logic  ldF0;
        logic  ldF1;
        logic  ldOut;
        fnOp_t fnSel;
        // also zeroes f0 for a fresh run
        logic  clrOverflow;
    } ctrlWord_t;

endpackage

`default_nettype wire

/* verilog/fibDataPkg.sv */
`default_nettype none

package fibDataPkg;

    //////////////////////////////
    // widths
    //////////////////////////////

    // result word width
    parameter int defaultDataWidth = 32;

    // width of the requested index n
    // six bits reach fib(63), well past the 32 bit wrap
    parameter int defaultIndexWidth = 6;

    //////////////////////////////
    // result word
    //////////////////////////////

    // what leaves the engine per request
    // value is fib(n) modulo 2^width
    typedef struct packed {
        logic [defaultDataWidth-1:0] value;
        // sticky, any add carried out of the top bit
        logic                        overflow;
    } fibResult_t;

endpackage

`default_nettype wire

/* verilog/fibDatapath.sv */
`timescale 1ns/100ps
`default_nettype none

module fibDatapath
    import fibDataPkg::*;
    import fibCtrlPkg::*;
#(
    parameter int dataWidth  = defaultDataWidth,
    parameter int indexWidth = defaultIndexWidth
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  ctrlWord_t             ctrl,
    input  logic [indexWidth-1:0] idxData,
    output logic                  cntZero,
    output fibResult_t            result
);

    // registers
    logic [indexWidth-1:0] indexReg;
    logic [indexWidth-1:0] cntReg;
    logic [dataWidth-1:0]  f0Reg;
    logic [dataWidth-1:0]  f1Reg;
    logic [dataWidth-1:0]  outReg;
    logic                  overflowReg;

    // function unit
    logic [dataWidth:0]    sum;
    logic [indexWidth-1:0] cntDec;
    logic [dataWidth-1:0]  busData;

    //////////////////////////////
    // function unit onto the bus
    //////////////////////////////

    // one extra bit keeps the carry
    assign sum    = {1'b0, f0Reg} + {1'b0, f1Reg};
    assign cntDec = cntReg - 1'b1;

    always_comb begin
        case (ctrl.fnSel)
            fnAdd:       busData = sum[dataWidth-1:0];
            fnOne:       busData = dataWidth'(1);
            fnPassIndex: busData = dataWidth'(indexReg);
            fnPassF1:    busData = f1Reg;
            fnDec:       busData = dataWidth'(cntDec);
            default:     busData = '0;
        endcase
    end

    //////////////////////////////
    // counter and overflow
    //////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cntReg      <= '0;
            overflowReg <= 1'b0;
        end else begin
            // low bits of the bus only
            if (ctrl.ldCnt) begin
                cntReg <= busData[indexWidth-1:0];
            end
            // sticky until the next run starts
            if (ctrl.clrOverflow) begin
                overflowReg <= 1'b0;
            end else if (ctrl.ldOut && ctrl.fnSel == fnAdd && sum[dataWidth]) begin
                overflowReg <= 1'b1;
            end
        end
    end

    //////////////////////////////
    // index and term registers
    //////////////////////////////

    always_ff @(posedge clk) begin
        // index comes from the receiver, not the bus
        if (ctrl.ldIndex) begin
            indexReg <= idxData;
        end
        // fib(0) term at start of a run
        if (ctrl.clrOverflow) begin
            f0Reg <= '0;
        end else if (ctrl.ldF0) begin
            f0Reg <= busData;
        end
        // f1 is fed from out only
        if (ctrl.ldF1) begin
            f1Reg <= outReg;
        end
        if (ctrl.ldOut) begin
            outReg <= busData;
        end
    end

    // loop test for the controller
    assign cntZero = (cntReg == '0);

    // f0 holds fib(n) once the loop ends
    assign result.value    = f0Reg;
    assign result.overflow = overflowReg;

endmodule

`default_nettype wire

/* verilog/fibEngine.sv */
`timescale 1ns/100ps
`default_nettype none

module fibEngine
    import fibDataPkg::*;
    import fibCtrlPkg::*;
#(
    parameter int dataWidth  = defaultDataWidth,
    parameter int indexWidth = defaultIndexWidth
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  inReq,
    input  logic [indexWidth-1:0] inIndex,
    input  logic                  outAck,
    output logic                  inAck,
    output logic                  outReq,
    output fibResult_t            outResult
);

    // receiver to controller and datapath
    logic                  idxValid;
    logic                  idxTake;
    logic [indexWidth-1:0] idxData;

    // controller and datapath
    ctrlWord_t             ctrl;
    logic                  cntZero;
    fibResult_t            dpResult;

    // controller to sender
    logic                  resultLoad;
    logic                  outFree;

    //////////////////////////////
    // three stages
    //////////////////////////////

    fibRequestIn #(.indexWidth(indexWidth)) uRequestIn (
        .clk(clk), .rstN(rstN), .inReq(inReq), .inIndex(inIndex),
        .idxTake(idxTake), .inAck(inAck), .idxValid(idxValid), .idxData(idxData)
    );

    fibController #(.indexWidth(indexWidth)) uController (
        .clk(clk), .rstN(rstN), .idxValid(idxValid), .cntZero(cntZero),
        .outFree(outFree), .idxTake(idxTake), .ctrl(ctrl), .resultLoad(resultLoad)
    );

    fibDatapath #(.dataWidth(dataWidth), .indexWidth(indexWidth)) uDatapath (
        .clk(clk), .rstN(rstN), .ctrl(ctrl), .idxData(idxData),
        .cntZero(cntZero), .result(dpResult)
    );

    fibResultOut #(.dataWidth(dataWidth)) uResultOut (
        .clk(clk), .rstN(rstN), .resultLoad(resultLoad), .result(dpResult),
        .outAck(outAck), .outFree(outFree), .outReq(outReq), .outResult(outResult)
    );

endmodule

`default_nettype wire

/* verilog/fibRequestIn.sv */
`timescale 1ns/100ps
`default_nettype none

module fibRequestIn
    import fibDataPkg::*;
#(
    parameter int indexWidth = defaultIndexWidth
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  inReq,
    input  logic [indexWidth-1:0] inIndex,
    input  logic                  idxTake,
    output logic                  inAck,
    output logic                  idxValid,
    output logic [indexWidth-1:0] idxData
);

    // receiver states
    typedef enum logic [1:0] {
        rxEmpty,
        rxHold,
        rxAck
    } rxState_t;

    rxState_t              rxState;
    logic [indexWidth-1:0] indexHold;

    //////////////////////////////
    // four phase receive
    //////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rxState <= rxEmpty;
        end else begin
            case (rxState)
                // new request seen
                rxEmpty: if (inReq) begin
                    rxState <= rxHold;
                end
                // offered until the controller grabs it
                rxHold: if (idxTake) begin
                    rxState <= rxAck;
                end
                // ack stays up until req returns low
                rxAck: if (!inReq) begin
                    rxState <= rxEmpty;
                end
                default: rxState <= rxEmpty;
            endcase
        end
    end

    // index captured once per request
    always_ff @(posedge clk) begin
        if (rxState == rxEmpty && inReq) begin
            indexHold <= inIndex;
        end
    end

    assign idxValid = (rxState == rxHold);
    assign inAck    = (rxState == rxAck);
    assign idxData  = indexHold;

endmodule

`default_nettype wire

/* verilog/fibResultOut.sv */
`timescale 1ns/100ps
`default_nettype none

module fibResultOut
    import fibDataPkg::*;
#(
    parameter int dataWidth = defaultDataWidth
) (
    input  logic       clk,
    input  logic       rstN,
    input  logic       resultLoad,
    input  fibResult_t result,
    input  logic       outAck,
    output logic       outFree,
    output logic       outReq,
    output fibResult_t outResult
);

    // sender states
    typedef enum logic [1:0] {
        txFree,
        txReq,
        txWaitLow
    } txState_t;

    txState_t             txState;
    logic [dataWidth-1:0] holdValue;
    logic                 holdOverflow;

    //////////////////////////////
    // four phase send
    //////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            txState <= txFree;
        end else begin
            case (txState)
                txFree: if (resultLoad) begin
                    txState <= txReq;
                end
                // drop req once the consumer has it
                txReq: if (outAck) begin
                    txState <= txWaitLow;
                end
                // free only after ack returns low
                txWaitLow: if (!outAck) begin
                    txState <= txFree;
                end
                default: txState <= txFree;
            endcase
        end
    end

    // held steady for the whole handshake
    always_ff @(posedge clk) begin
        if (resultLoad && txState == txFree) begin
            holdValue    <= result.value;
            holdOverflow <= result.overflow;
        end
    end

    assign outFree            = (txState == txFree);
    assign outReq             = (txState == txReq);
    assign outResult.value    = holdValue;
    assign outResult.overflow = holdOverflow;

endmodule

`default_nettype wire
